// File: sources.f
source/wb_pkg.sv
source/store_align.sv
source/load_extract.sv
source/mem_stage.sv
source/wb_stage.sv
source/regfile.sv
source/mem_wb_top.sv
testbench/tb_data_mem.sv
testbench/tb_mem_wb.sv

// File: Makefile
# Verilator flow for the memory and write-back back end

VERILATOR  ?= verilator
FILELIST   ?= sources.f
TOP        ?= tb_mem_wb
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing -Wno-fatal -j 0
FAIL_MSG   ?= Simulation failed
PASS_MSG   ?= Simulation passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# result comes from the log, not the exit status of the run
sim: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "failure reported in $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "no result found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/tb_mem_wb.sv
`default_nettype none

module tb_mem_wb;
	timeunit 1ns;
	timeprecision 1ps;
	import wb_pkg::*;

	// cycles any single wait may take
	localparam int TIMEOUT = 100;

	logic     clk;
	logic     rst;
	logic     ex_valid;
	logic     ex_ready;
	xlen_t    ex_pc;
	inst_t    ex_inst;
	xlen_t    ex_result;
	xlen_t    ex_store_data;
	reg_idx_t ex_rd;
	logic     ex_wen;
	logic     mem_req_valid;
	logic     mem_req_ready;
	logic     mem_req_write;
	xlen_t    mem_req_addr;
	xlen_t    mem_req_wdata;
	strb_t    mem_req_wstrb;
	logic     mem_resp_valid;
	xlen_t    mem_resp_rdata;
	reg_idx_t rf_raddr;
	xlen_t    rf_rdata;
	logic     retire_valid;
	xlen_t    retire_pc;
	inst_t    retire_inst;
	count_t   load_count;
	count_t   store_count;

	integer   seed = 58;
	int       errors = 0;
	int       test_start_errors = 0;
	int       tests_run = 0;
	int       tests_failed = 0;
	int       total_loads = 0;
	int       total_stores = 0;
	// cycles spent waiting on ex_ready
	int       stalls = 0;
	logic     stuck = 1'b0;
	xlen_t    next_pc = 64'h8000_0000;

	// issue order and retire order
	xlen_t    exp_pc_q [$];
	inst_t    exp_inst_q [$];
	xlen_t    ret_pc_q [$];
	inst_t    ret_inst_q [$];

	mem_wb_top u_dut (.*);

	tb_data_mem u_mem (
		.clk        (clk),
		.rst        (rst),
		.req_valid  (mem_req_valid),
		.req_ready  (mem_req_ready),
		.req_write  (mem_req_write),
		.req_addr   (mem_req_addr),
		.req_wdata  (mem_req_wdata),
		.req_wstrb  (mem_req_wstrb),
		.resp_valid (mem_resp_valid),
		.resp_rdata (mem_resp_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// retire outputs are stable mid-cycle
	always @(negedge clk) begin
		if (!rst && retire_valid) begin
			ret_pc_q.push_back(retire_pc);
			ret_inst_q.push_back(retire_inst);
		end
	end

	task automatic check_xlen(input string name, input xlen_t got, input xlen_t exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input count_t got, input count_t exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_inst(input string name, input inst_t got, input inst_t exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	// addi rd, x0, 0
	function automatic inst_t alu_inst(input reg_idx_t rd);
		return {12'h000, 5'd0, 3'b000, rd, 7'b0010011};
	endfunction

	function automatic inst_t load_inst(input logic [2:0] f3, input reg_idx_t rd);
		return {12'h000, 5'd0, f3, rd, OPC_LOAD};
	endfunction

	function automatic inst_t store_inst(input logic [2:0] f3);
		return {7'h00, 5'd0, 5'd0, f3, 5'd0, OPC_STORE};
	endfunction

	// low funct3 bits give log2 of the access size
	function automatic xlen_t store_result(input logic [2:0] f3, input int lane,
			input xlen_t old, input xlen_t data);
		xlen_t v;
		v = old;
		for (int b = 0; b < (1 << f3[1:0]); b++) begin
			v[(lane + b) * 8 +: 8] = data[b * 8 +: 8];
		end
		return v;
	endfunction

	// funct3 bit 2 selects zero extension
	function automatic xlen_t load_result(input logic [2:0] f3, input int lane,
			input xlen_t word);
		int    n;
		xlen_t v;
		n = 1 << f3[1:0];
		v = '0;
		for (int b = 0; b < n; b++) begin
			v[b * 8 +: 8] = word[(lane + b) * 8 +: 8];
		end
		if (!f3[2] && n < 8 && v[n * 8 - 1]) begin
			for (int b = n; b < 8; b++) begin
				v[b * 8 +: 8] = 8'hff;
			end
		end
		return v;
	endfunction

	// entered and left just after a rising edge
	task automatic send(input inst_t inst, input xlen_t result, input xlen_t sdata,
			input reg_idx_t rd, input logic wen);
		int waited;
		ex_valid <= 1'b1;
		ex_pc <= next_pc;
		ex_inst <= inst;
		ex_result <= result;
		ex_store_data <= sdata;
		ex_rd <= rd;
		ex_wen <= wen;
		exp_pc_q.push_back(next_pc);
		exp_inst_q.push_back(inst);
		next_pc = next_pc + 64'd4;
		if (inst[6:0] == OPC_LOAD) begin
			total_loads++;
		end
		if (inst[6:0] == OPC_STORE) begin
			total_stores++;
		end
		waited = 0;
		@(negedge clk);
		while (!ex_ready && !stuck) begin
			waited++;
			if (waited > TIMEOUT) begin
				$display("timeout at %0t ns: ex_ready stayed low", $time);
				errors++;
				stuck = 1'b1;
			end else begin
				@(negedge clk);
			end
		end
		stalls += waited;
		// transfer edge
		@(posedge clk);
	endtask

	// stop issuing, wait for all retires, compare order
	task automatic drain();
		int waited;
		ex_valid <= 1'b0;
		waited = 0;
		while (ret_pc_q.size() < exp_pc_q.size() && !stuck) begin
			@(negedge clk);
			waited++;
			if (waited > TIMEOUT) begin
				$display("timeout at %0t ns: only %0d of %0d instructions retired",
					$time, ret_pc_q.size(), exp_pc_q.size());
				errors++;
				stuck = 1'b1;
			end
		end
		// a repeated retire would land here
		repeat (2) @(negedge clk);
		if (ret_pc_q.size() != exp_pc_q.size()) begin
			$display("retire count wrong: %0d retired, %0d issued",
				ret_pc_q.size(), exp_pc_q.size());
			errors++;
		end
		while (ret_pc_q.size() > 0 && exp_pc_q.size() > 0) begin
			check_xlen("retire_pc", ret_pc_q.pop_front(), exp_pc_q.pop_front());
			check_inst("retire_inst", ret_inst_q.pop_front(), exp_inst_q.pop_front());
		end
		exp_pc_q.delete();
		exp_inst_q.delete();
		ret_pc_q.delete();
		ret_inst_q.delete();
		@(posedge clk);
	endtask

	task automatic read_reg(input reg_idx_t r, output xlen_t value);
		rf_raddr <= r;
		@(negedge clk);
		value = rf_rdata;
		@(posedge clk);
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == test_start_errors) begin
			$display("test %-14s ok", name);
		end else begin
			tests_failed++;
			$display("test %-14s FAILED, %0d errors", name, errors - test_start_errors);
		end
		test_start_errors = errors;
	endtask

	task automatic test_alu_writeback();
		xlen_t vals [1:8];
		xlen_t got;
		stalls = 0;
		// back to back, one per cycle
		for (int r = 1; r <= 8; r++) begin
			vals[r] = {$random(seed), $random(seed)};
			send(alu_inst(reg_idx_t'(r)), vals[r], '0, reg_idx_t'(r), 1'b1);
		end
		// each alu item leaves as the next one enters
		if (stalls != 0) begin
			$display("ex_ready dropped for %0d cycles in a back-to-back alu stream", stalls);
			errors++;
		end
		drain();
		for (int r = 1; r <= 8; r++) begin
			read_reg(reg_idx_t'(r), got);
			check_xlen($sformatf("rf_rdata x%0d", r), got, vals[r]);
		end
	endtask

	task automatic test_x0();
		xlen_t got;
		send(alu_inst(5'd0), 64'hdead_beef_0bad_f00d, '0, 5'd0, 1'b1);
		drain();
		read_reg(5'd0, got);
		check_xlen("rf_rdata x0", got, '0);
	endtask

	// words 0..7 take the stores
	task automatic test_stores();
		int    idx;
		xlen_t data;
		xlen_t want;
		idx = 0;
		for (int sz = 0; sz < 4; sz++) begin
			for (int lane = 0; lane < 8; lane += (1 << sz)) begin
				data = {$random(seed), $random(seed)};
				want = store_result(3'(sz), lane, u_mem.mem[idx], data);
				send(store_inst(3'(sz)), xlen_t'(idx * 8 + lane), data, 5'd0, 1'b0);
				drain();
				check_xlen($sformatf("mem[%0d]", idx), u_mem.mem[idx], want);
				idx = (idx + 1) % 8;
			end
		end
	endtask

	// words 8..15 still hold the fill
	task automatic test_loads();
		logic [2:0] f3;
		int         idx;
		xlen_t      want;
		xlen_t      got;
		idx = 8;
		for (int k = 0; k < 7; k++) begin
			f3 = 3'(k);
			for (int lane = 0; lane < 8; lane += (1 << f3[1:0])) begin
				want = load_result(f3, lane, u_mem.mem[idx]);
				send(load_inst(f3, 5'd10), xlen_t'(idx * 8 + lane), '0, 5'd10, 1'b1);
				drain();
				read_reg(5'd10, got);
				check_xlen($sformatf("rf_rdata x10 f3=%0d lane=%0d", f3, lane), got, want);
				idx = 8 + (idx + 1) % 8;
			end
		end
	endtask

	// random mix whose retire order drain checks
	task automatic run_stream(input int n, input bit mem_only);
		int         kind;
		int         idx;
		int         lane;
		logic [2:0] f3;
		for (int i = 0; i < n; i++) begin
			kind = mem_only ? 1 + $unsigned($random(seed)) % 2 : $unsigned($random(seed)) % 3;
			idx = $unsigned($random(seed)) % 16;
			f3 = 3'($unsigned($random(seed)) % 7);
			// align the lane to the size
			lane = ($unsigned($random(seed)) % 8) & ~((1 << f3[1:0]) - 1);
			case (kind)
				0: send(alu_inst(5'd20), {$random(seed), $random(seed)}, '0, 5'd20, 1'b1);
				1: send(load_inst(f3, 5'd21), xlen_t'(idx * 8 + lane), '0, 5'd21, 1'b1);
				default: send(store_inst({1'b0, f3[1:0]}), xlen_t'(idx * 8 + lane),
					{$random(seed), $random(seed)}, 5'd0, 1'b0);
			endcase
		end
		drain();
	endtask

	task automatic test_counters();
		run_stream(20, 1'b1);
		check_count("load_count", load_count, count_t'(total_loads));
		check_count("store_count", store_count, count_t'(total_stores));
	endtask

	initial begin
		rst = 1'b1;
		ex_valid = 1'b0;
		ex_pc = '0;
		ex_inst = '0;
		ex_result = '0;
		ex_store_data = '0;
		ex_rd = '0;
		ex_wen = 1'b0;
		rf_raddr = '0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;

		test_alu_writeback();
		end_test("alu_writeback");
		test_x0();
		end_test("x0_suppress");
		test_stores();
		end_test("stores");
		test_loads();
		end_test("loads");
		run_stream(40, 1'b0);
		end_test("back_pressure");
		test_counters();
		end_test("counters");

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/tb_data_mem.sv
`default_nettype none

module tb_data_mem (
	input  logic             clk,
	input  logic             rst,
	input  logic             req_valid,
	output logic             req_ready,
	input  logic             req_write,
	input  wb_pkg::xlen_t    req_addr,
	input  wb_pkg::xlen_t    req_wdata,
	input  wb_pkg::strb_t    req_wstrb,
	output logic             resp_valid,
	output wb_pkg::xlen_t    resp_rdata
);
	timeunit 1ns;
	timeprecision 1ps;
	import wb_pkg::*;

	// 16 little-endian words, 128 bytes
	localparam int DEPTH = 16;

	xlen_t      mem [DEPTH];
	integer     seed = 58;
	logic       busy;
	int         delay;
	logic [3:0] idx;

	// word index from the byte address
	assign idx = req_addr[6:3];
	// one request at a time
	assign req_ready = !busy;

	always @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			resp_valid <= 1'b0;
			resp_rdata <= '0;
			delay <= 0;
			// fill byte depends on the full byte address
			for (int w = 0; w < DEPTH; w++) begin
				for (int b = 0; b < STRB_W; b++) begin
					mem[w][b*8 +: 8] <= 8'((w * 8 + b) * 29 + 55);
				end
			end
		end else begin
			resp_valid <= 1'b0;
			if (req_valid && req_ready) begin
				// read data is the word before any write
				resp_rdata <= mem[idx];
				for (int b = 0; b < STRB_W; b++) begin
					if (req_write && req_wstrb[b]) begin
						mem[idx][b*8 +: 8] <= req_wdata[b*8 +: 8];
					end
				end
				busy <= 1'b1;
				// 0..3 extra cycles before the response
				delay <= $unsigned($random(seed)) % 4;
			end else if (busy) begin
				if (delay == 0) begin
					resp_valid <= 1'b1;
					busy <= 1'b0;
				end else begin
					delay <= delay - 1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: source/mem_wb_top.sv
`default_nettype none

module mem_wb_top (
	input  logic                clk,
	input  logic                rst,
	// execute side
	input  logic                ex_valid,
	output logic                ex_ready,
	input  wb_pkg::xlen_t       ex_pc,
	input  wb_pkg::inst_t       ex_inst,
	input  wb_pkg::xlen_t       ex_result,
	input  wb_pkg::xlen_t       ex_store_data,
	input  wb_pkg::reg_idx_t    ex_rd,
	input  logic                ex_wen,
	// data memory
	output logic                mem_req_valid,
	input  logic                mem_req_ready,
	output logic                mem_req_write,
	output wb_pkg::xlen_t       mem_req_addr,
	output wb_pkg::xlen_t       mem_req_wdata,
	output wb_pkg::strb_t       mem_req_wstrb,
	input  logic                mem_resp_valid,
	input  wb_pkg::xlen_t       mem_resp_rdata,
	// decode-side read port
	input  wb_pkg::reg_idx_t    rf_raddr,
	output wb_pkg::xlen_t       rf_rdata,
	// retire
	output logic                retire_valid,
	output wb_pkg::xlen_t       retire_pc,
	output wb_pkg::inst_t       retire_inst,
	output wb_pkg::count_t      load_count,
	output wb_pkg::count_t      store_count
);
	import wb_pkg::*;

	// mem_stage to wb_stage
	logic      m_valid;
	xlen_t     m_pc;
	inst_t     m_inst;
	mem_kind_t m_kind;
	reg_idx_t  m_rd;
	logic      m_wen;
	xlen_t     m_wdata;

	// wb_stage to regfile
	logic      rf_wen;
	reg_idx_t  rf_waddr;
	xlen_t     rf_wdata;

	mem_stage u_mem_stage (
		.clk            (clk),
		.rst            (rst),
		.ex_valid       (ex_valid),
		.ex_ready       (ex_ready),
		.ex_pc          (ex_pc),
		.ex_inst        (ex_inst),
		.ex_result      (ex_result),
		.ex_store_data  (ex_store_data),
		.ex_rd          (ex_rd),
		.ex_wen         (ex_wen),
		.mem_req_valid  (mem_req_valid),
		.mem_req_ready  (mem_req_ready),
		.mem_req_write  (mem_req_write),
		.mem_req_addr   (mem_req_addr),
		.mem_req_wdata  (mem_req_wdata),
		.mem_req_wstrb  (mem_req_wstrb),
		.mem_resp_valid (mem_resp_valid),
		.mem_resp_rdata (mem_resp_rdata),
		.m_valid        (m_valid),
		.m_pc           (m_pc),
		.m_inst         (m_inst),
		.m_kind         (m_kind),
		.m_rd           (m_rd),
		.m_wen          (m_wen),
		.m_wdata        (m_wdata)
	);

	wb_stage u_wb_stage (
		.clk          (clk),
		.rst          (rst),
		.m_valid      (m_valid),
		.m_pc         (m_pc),
		.m_inst       (m_inst),
		.m_kind       (m_kind),
		.m_rd         (m_rd),
		.m_wen        (m_wen),
		.m_wdata      (m_wdata),
		.rf_wen       (rf_wen),
		.rf_waddr     (rf_waddr),
		.rf_wdata     (rf_wdata),
		.retire_valid (retire_valid),
		.retire_pc    (retire_pc),
		.retire_inst  (retire_inst),
		.load_count   (load_count),
		.store_count  (store_count)
	);

	regfile u_regfile (
		.clk   (clk),
		.rst   (rst),
		.wen   (rf_wen),
		.waddr (rf_waddr),
		.wdata (rf_wdata),
		.raddr (rf_raddr),
		.rdata (rf_rdata)
	);

endmodule

`default_nettype wire

// File: source/regfile.sv
`default_nettype none

module regfile (
	input  logic                clk,
	input  logic                rst,
	input  logic                wen,
	input  wb_pkg::reg_idx_t    waddr,
	input  wb_pkg::xlen_t       wdata,
	input  wb_pkg::reg_idx_t    raddr,
	output wb_pkg::xlen_t       rdata
);
	import wb_pkg::*;

	// x1..x31, x0 has no storage
	xlen_t regs [NUM_REGS-1:1];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// combinational read, x0 reads zero
	assign rdata = (raddr == '0) ? '0 : regs[raddr];

endmodule

`default_nettype wire

// File: source/wb_stage.sv
`default_nettype none

module wb_stage (
	input  logic                clk,
	input  logic                rst,
	// from mem_stage, always accepted
	input  logic                m_valid,
	input  wb_pkg::xlen_t       m_pc,
	input  wb_pkg::inst_t       m_inst,
	input  wb_pkg::mem_kind_t   m_kind,
	input  wb_pkg::reg_idx_t    m_rd,
	input  logic                m_wen,
	input  wb_pkg::xlen_t       m_wdata,
	// register file write port
	output logic                rf_wen,
	output wb_pkg::reg_idx_t    rf_waddr,
	output wb_pkg::xlen_t       rf_wdata,
	// retire and access counts
	output logic                retire_valid,
	output wb_pkg::xlen_t       retire_pc,
	output wb_pkg::inst_t       retire_inst,
	output wb_pkg::count_t      load_count,
	output wb_pkg::count_t      store_count
);
	import wb_pkg::*;

	logic     wb_valid;
	xlen_t    wb_pc;
	inst_t    wb_inst;
	reg_idx_t wb_rd;
	logic     wb_wen;
	xlen_t    wb_wdata;

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_valid <= 1'b0;
			load_count <= '0;
			store_count <= '0;
		end else begin
			wb_valid <= m_valid;
			// count as the item enters, visible with its retire
			if (m_valid && m_kind == MEM_LOAD) begin
				load_count <= load_count + 1'b1;
			end
			if (m_valid && m_kind == MEM_STORE) begin
				store_count <= store_count + 1'b1;
			end
		end
	end

	// payload follows valid items only
	always_ff @(posedge clk) begin
		if (m_valid) begin
			wb_pc <= m_pc;
			wb_inst <= m_inst;
			wb_rd <= m_rd;
			wb_wen <= m_wen;
			wb_wdata <= m_wdata;
		end
	end

	// writes to x0 dropped here
	assign rf_wen = wb_valid && wb_wen && (wb_rd != '0);
	assign rf_waddr = wb_rd;
	assign rf_wdata = wb_wdata;

	assign retire_valid = wb_valid;
	assign retire_pc = wb_pc;
	assign retire_inst = wb_inst;

endmodule

`default_nettype wire

// File: source/mem_stage.sv
`default_nettype none

module mem_stage (
	input  logic                clk,
	input  logic                rst,
	// from execute
	input  logic                ex_valid,
	output logic                ex_ready,
	input  wb_pkg::xlen_t       ex_pc,
	input  wb_pkg::inst_t       ex_inst,
	input  wb_pkg::xlen_t       ex_result,
	input  wb_pkg::xlen_t       ex_store_data,
	input  wb_pkg::reg_idx_t    ex_rd,
	input  logic                ex_wen,
	// data memory port
	output logic                mem_req_valid,
	input  logic                mem_req_ready,
	output logic                mem_req_write,
	output wb_pkg::xlen_t       mem_req_addr,
	output wb_pkg::xlen_t       mem_req_wdata,
	output wb_pkg::strb_t       mem_req_wstrb,
	input  logic                mem_resp_valid,
	input  wb_pkg::xlen_t       mem_resp_rdata,
	// to write-back
	output logic                m_valid,
	output wb_pkg::xlen_t       m_pc,
	output wb_pkg::inst_t       m_inst,
	output wb_pkg::mem_kind_t   m_kind,
	output wb_pkg::reg_idx_t    m_rd,
	output logic                m_wen,
	output wb_pkg::xlen_t       m_wdata
);
	import wb_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_REQ,
		S_WAIT
	} state_t;

	state_t    state;
	mem_kind_t ex_kind;
	logic      accept;
	logic      resp_done;

	// held item
	logic      held_valid;
	xlen_t     held_pc;
	inst_t     held_inst;
	xlen_t     held_result;
	xlen_t     held_store_data;
	reg_idx_t  held_rd;
	logic      held_wen;
	mem_kind_t held_kind;

	strb_t     st_strb;
	xlen_t     ld_value;

	// classify the incoming instruction by opcode
	always_comb begin
		case (ex_inst[6:0])
			OPC_LOAD:  ex_kind = MEM_LOAD;
			OPC_STORE: ex_kind = MEM_STORE;
			default:   ex_kind = MEM_NONE;
		endcase
	end

	// response counts only once the request went out
	assign resp_done = mem_resp_valid &&
		(state == S_WAIT || (state == S_REQ && mem_req_ready));

	// alu items leave at once, memory items on their response
	assign m_valid = held_valid && (held_kind == MEM_NONE || resp_done);
	// free slot, or the held item leaves this cycle
	assign ex_ready = !held_valid || m_valid;
	assign accept = ex_valid && ex_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			held_valid <= 1'b0;
			state <= S_IDLE;
		end else if (accept) begin
			held_valid <= 1'b1;
			// memory items start requesting next cycle
			state <= (ex_kind == MEM_NONE) ? S_IDLE : S_REQ;
		end else begin
			if (m_valid) begin
				held_valid <= 1'b0;
			end
			case (state)
				S_REQ: begin
					if (resp_done) begin
						state <= S_IDLE;
					end else if (mem_req_ready) begin
						state <= S_WAIT;
					end
				end
				S_WAIT: begin
					if (resp_done) begin
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// payload, only loaded on accept
	always_ff @(posedge clk) begin
		if (accept) begin
			held_pc <= ex_pc;
			held_inst <= ex_inst;
			held_result <= ex_result;
			held_store_data <= ex_store_data;
			held_rd <= ex_rd;
			held_wen <= ex_wen;
			held_kind <= ex_kind;
		end
	end

	// request fields come straight from the held item
	store_align u_store_align (
		.funct3     (held_inst[14:12]),
		.addr_lane  (held_result[LANE_W-1:0]),
		.store_data (held_store_data),
		.wdata      (mem_req_wdata),
		.wstrb      (st_strb)
	);

	assign mem_req_valid = (state == S_REQ);
	assign mem_req_write = (held_kind == MEM_STORE);
	assign mem_req_addr = held_result;
	// no strobes on a read
	assign mem_req_wstrb = mem_req_write ? st_strb : '0;

	load_extract u_load_extract (
		.funct3    (held_inst[14:12]),
		.addr_lane (held_result[LANE_W-1:0]),
		.rdata     (mem_resp_rdata),
		.value     (ld_value)
	);

	assign m_pc = held_pc;
	assign m_inst = held_inst;
	assign m_kind = held_kind;
	assign m_rd = held_rd;
	// stores never write a register
	assign m_wen = held_wen && (held_kind != MEM_STORE);
	assign m_wdata = (held_kind == MEM_LOAD) ? ld_value : held_result;

endmodule

`default_nettype wire

// File: source/load_extract.sv
`default_nettype none

module load_extract (
	input  logic [2:0]                   funct3,
	input  logic [wb_pkg::LANE_W-1:0]    addr_lane,
	input  wb_pkg::xlen_t                rdata,
	output wb_pkg::xlen_t                value
);
	import wb_pkg::*;

	// accessed bytes moved down to lane 0
	xlen_t shifted;

	assign shifted = rdata >> {addr_lane, 3'b000};

	always_comb begin
		case (funct3)
			// signed sizes
			F3_B:    value = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
			F3_H:    value = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
			F3_W:    value = {{(XLEN-32){shifted[31]}}, shifted[31:0]};
			// unsigned sizes
			F3_BU:   value = {{(XLEN-8){1'b0}}, shifted[7:0]};
			F3_HU:   value = {{(XLEN-16){1'b0}}, shifted[15:0]};
			F3_WU:   value = {{(XLEN-32){1'b0}}, shifted[31:0]};
			// full word, lane is always zero here
			F3_D:    value = rdata;
			default: value = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: source/store_align.sv
`default_nettype none

module store_align (
	input  logic [2:0]                   funct3,
	input  logic [wb_pkg::LANE_W-1:0]    addr_lane,
	input  wb_pkg::xlen_t                store_data,
	output wb_pkg::xlen_t                wdata,
	output wb_pkg::strb_t                wstrb
);
	import wb_pkg::*;

	// byte enables of the access before lane shift
	strb_t size_mask;
	// size_mask expanded to bits
	xlen_t keep_bits;

	always_comb begin
		case (funct3)
			F3_B:    size_mask = 8'h01;
			F3_H:    size_mask = 8'h03;
			F3_W:    size_mask = 8'h0f;
			F3_D:    size_mask = 8'hff;
			// not a store size
			default: size_mask = 8'h00;
		endcase
	end

	always_comb begin
		for (int i = 0; i < STRB_W; i++) begin
			keep_bits[i*8 +: 8] = {8{size_mask[i]}};
		end
	end

	// drop the unused upper bytes, then move to the lane
	// accesses crossing the 8-byte word lose their top bytes
	assign wdata = (store_data & keep_bits) << {addr_lane, 3'b000};
	assign wstrb = size_mask << addr_lane;

endmodule

`default_nettype wire

// File: source/wb_pkg.sv
`default_nettype none

package wb_pkg;

	// datapath widths
	localparam int XLEN       = 64;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS   = 32;
	// bytes per data word and the lane index that picks one
	localparam int STRB_W     = 8;
	localparam int LANE_W     = 3;

	// major opcodes, inst[6:0]
	localparam logic [6:0] OPC_LOAD  = 7'b0000011;
	localparam logic [6:0] OPC_STORE = 7'b0100011;

	// funct3, inst[14:12]
	// bit 2 set means zero-extend on loads
	localparam logic [2:0] F3_B  = 3'b000;
	localparam logic [2:0] F3_H  = 3'b001;
	localparam logic [2:0] F3_W  = 3'b010;
	localparam logic [2:0] F3_D  = 3'b011;
	localparam logic [2:0] F3_BU = 3'b100;
	localparam logic [2:0] F3_HU = 3'b101;
	localparam logic [2:0] F3_WU = 3'b110;

	typedef logic [XLEN-1:0]       xlen_t;
	typedef logic [REG_ADDR_W-1:0] reg_idx_t;
	typedef logic [STRB_W-1:0]     strb_t;
	typedef logic [31:0]           inst_t;
	typedef logic [31:0]           count_t;

	// memory class of an instruction
	typedef enum logic [1:0] {
		MEM_NONE,
		MEM_LOAD,
		MEM_STORE
	} mem_kind_t;

endpackage

`default_nettype wire
